// File: vlog.f
verilog/dcache_pkg.sv
verilog/dcache_req_buf.sv
verilog/dcache_ways.sv
verilog/dcache_lru.sv
verilog/dcache_fsm.sv
verilog/dcache_top.sv
verification/dcache_mem_model.sv
verification/dcache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module dcache_tb

out=$(./obj_dir/Vdcache_tb)
echo "$out"
echo "$out" | grep -qx "Simulation PASSED"

// File: verification/dcache_tb.sv
////////////////////////////////////////////////////////////
// table-driven testbench for the data cache
// loads are checked against a shadow copy of memory
////////////////////////////////////////////////////////////
module dcache_tb;
    import dcache_pkg::*;

    typedef struct packed {
        req_op_e     op;
        logic [31:0] addr;
        logic [3:0]  strb;
        logic [31:0] data;
        logic        miss;
    } row_t;

    localparam int num_rows   = 19;
    localparam int max_cycles = 4 + num_rows * 12;

    logic         clk;
    logic         rstn;
    logic         req_valid;
    req_op_e      req_op;
    logic [31:0]  req_addr;
    logic [3:0]   req_wstrb;
    logic [31:0]  req_wdata;
    logic         req_ready;
    logic [31:0]  rdata;
    logic         rdata_valid;
    logic         mem_req;
    logic         mem_wr;
    logic [31:0]  mem_addr;
    logic [31:0]  mem_wdata;
    logic [3:0]   mem_wstrb;
    logic         mem_addr_ok;
    logic         mem_data_ok;
    logic [127:0] mem_rdata;
    int           rd_count;
    int           wr_count;
    logic [3:0]   last_wstrb;

    int           errors;
    int           checks;
    int           cycles = 0;
    logic [31:0]  shadow [1024];

    // set 3 holds tags 0, 1 and 2 at 0x030, 0x130, 0x230
    row_t rows [num_rows] = '{
        '{op_load,  32'h0000_0034, 4'h0, 32'h0000_0000, 1'b1},
        '{op_load,  32'h0000_0048, 4'h0, 32'h0000_0000, 1'b1},
        '{op_load,  32'h0000_003c, 4'h0, 32'h0000_0000, 1'b0},
        '{op_load,  32'h0000_0040, 4'h0, 32'h0000_0000, 1'b0},
        '{op_store, 32'h0000_0038, 4'h3, 32'h1234_5678, 1'b0},
        '{op_load,  32'h0000_0038, 4'h0, 32'h0000_0000, 1'b0},
        '{op_store, 32'h0000_00a4, 4'hc, 32'hdead_beef, 1'b1},
        '{op_load,  32'h0000_00a4, 4'h0, 32'h0000_0000, 1'b1},
        '{op_load,  32'h0000_0130, 4'h0, 32'h0000_0000, 1'b1},
        '{op_load,  32'h0000_0034, 4'h0, 32'h0000_0000, 1'b0},
        '{op_load,  32'h0000_0230, 4'h0, 32'h0000_0000, 1'b1},
        '{op_load,  32'h0000_003c, 4'h0, 32'h0000_0000, 1'b0},
        '{op_load,  32'h0000_0130, 4'h0, 32'h0000_0000, 1'b1},
        '{op_inval, 32'h0000_0030, 4'h0, 32'h0000_0000, 1'b0},
        '{op_load,  32'h0000_0038, 4'h0, 32'h0000_0000, 1'b1},
        '{op_load,  32'h0000_0134, 4'h0, 32'h0000_0000, 1'b1},
        '{op_store, 32'h0000_013c, 4'hf, 32'h0bad_f00d, 1'b0},
        '{op_load,  32'h0000_013c, 4'h0, 32'h0000_0000, 1'b0},
        '{op_load,  32'h0000_0044, 4'h0, 32'h0000_0000, 1'b0}
    };

    dcache_top uut (.*);

    dcache_mem_model u_mem (.*);

    always #5 clk = ~clk;

    // hang guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the cache did not finish the table in %0d cycles", max_cycles);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic apply_row(input row_t r);
        int         rd_before;
        int         wr_before;
        int         lat;
        logic [9:0] widx;
        @(posedge clk);
        #1;
        rd_before = rd_count;
        wr_before = wr_count;
        widx      = r.addr[11:2];
        req_valid = 1'b1;
        req_op    = r.op;
        req_addr  = r.addr;
        req_wstrb = r.strb;
        req_wdata = r.data;
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        if (r.op == op_load) begin
            // lookup cycle counts as 1
            lat = 1;
            @(negedge clk);
            while (!rdata_valid) begin
                @(negedge clk);
                lat++;
            end
            compare_value("rdata", rdata, shadow[widx]);
            if (!r.miss) begin
                compare_value("hit_latency", lat, 1);
            end
            compare_value("mem_reads", rd_count - rd_before, {31'b0, r.miss});
            compare_value("mem_writes", wr_count - wr_before, 0);
        end else begin
            @(negedge clk);
            while (!req_ready) @(negedge clk);
            if (r.op == op_store) begin
                for (int b = 0; b < 4; b++) begin
                    if (r.strb[b]) begin
                        shadow[widx][b * 8 +: 8] = r.data[b * 8 +: 8];
                    end
                end
                compare_value("mem_wstrb", {28'b0, last_wstrb}, {28'b0, r.strb});
                compare_value("mem_writes", wr_count - wr_before, 1);
            end else begin
                compare_value("mem_writes", wr_count - wr_before, 0);
            end
            compare_value("mem_reads", rd_count - rd_before, 0);
        end
    endtask

    initial begin
        clk       = 1'b0;
        rstn      = 1'b0;
        req_valid = 1'b0;
        req_op    = op_load;
        req_addr  = '0;
        req_wstrb = '0;
        req_wdata = '0;
        errors    = 0;
        checks    = 0;
        for (int i = 0; i < 1024; i++) begin
            shadow[i] = 32'(i * 4) ^ 32'ha5a5_0000;
        end
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        compare_value("req_ready", {31'b0, req_ready}, 1);
        compare_value("mem_req", {31'b0, mem_req}, 0);
        compare_value("rdata_valid", {31'b0, rdata_valid}, 0);
        for (int i = 0; i < num_rows; i++) begin
            apply_row(rows[i]);
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: verification/dcache_mem_model.sv
////////////////////////////////////////////////////////////
// behavioral memory behind the cache, random handshake delays
// counts line reads and word writes for the testbench
////////////////////////////////////////////////////////////
module dcache_mem_model (
    input  logic         clk,
    input  logic         mem_req,
    input  logic         mem_wr,
    input  logic [31:0]  mem_addr,
    input  logic [31:0]  mem_wdata,
    input  logic [3:0]   mem_wstrb,
    output logic         mem_addr_ok,
    output logic         mem_data_ok,
    output logic [127:0] mem_rdata,
    output int           rd_count,
    output int           wr_count,
    output logic [3:0]   last_wstrb
);
    // 4 KB of words
    logic [31:0] mem [1024];
    logic [9:0]  base;
    logic        is_write;
    int unsigned delay;

    initial begin
        void'($urandom(86));
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'(i * 4) ^ 32'ha5a5_0000;
        end
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        rd_count    = 0;
        wr_count    = 0;
        last_wstrb  = '0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_req) begin
                delay = $urandom % 4;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                // request is held stable until accepted
                is_write    = mem_wr;
                base        = mem_addr[11:2];
                mem_addr_ok = 1'b1;
                if (is_write) begin
                    for (int b = 0; b < 4; b++) begin
                        if (mem_wstrb[b]) begin
                            mem[base][b * 8 +: 8] = mem_wdata[b * 8 +: 8];
                        end
                    end
                    last_wstrb = mem_wstrb;
                    wr_count++;
                end
                @(posedge clk);
                #1;
                mem_addr_ok = 1'b0;
                if (!is_write) begin
                    delay = $urandom % 4;
                    repeat (delay) begin
                        @(posedge clk);
                        #1;
                    end
                    // line starts at the requested word
                    mem_rdata   = {mem[base + 10'd3], mem[base + 10'd2],
                                   mem[base + 10'd1], mem[base]};
                    mem_data_ok = 1'b1;
                    rd_count++;
                    @(posedge clk);
                    #1;
                    mem_data_ok = 1'b0;
                end
            end
        end
    end

endmodule

// File: verilog/dcache_top.sv
////////////////////////////////////////////////////////////
// data cache top, pipeline port on one side, memory on the other
////////////////////////////////////////////////////////////
module dcache_top (
    input  logic               clk,
    input  logic               rstn,
    // pipeline side
    input  logic               req_valid,
    input  dcache_pkg::req_op_e req_op,
    input  logic [31:0]        req_addr,
    input  logic [3:0]         req_wstrb,
    input  logic [31:0]        req_wdata,
    output logic               req_ready,
    output logic [31:0]        rdata,
    output logic               rdata_valid,
    // memory side
    output logic               mem_req,
    output logic               mem_wr,
    output logic [31:0]        mem_addr,
    output logic [31:0]        mem_wdata,
    output logic [3:0]         mem_wstrb,
    input  logic               mem_addr_ok,
    input  logic               mem_data_ok,
    input  logic [127:0]       mem_rdata
);
    import dcache_pkg::*;

    req_op_e     buf_op;
    logic [31:0] buf_addr;
    logic [3:0]  buf_wstrb;
    logic [31:0] buf_wdata;
    logic        buf_we;
    logic [1:0]  way_we;
    logic        refill;
    logic        inval_set;
    logic        sel_way;
    logic        sel_return;
    logic        use0;
    logic        use1;
    logic [1:0]  hit;
    logic        victim;

    // reads fetch the whole line
    assign mem_addr  = mem_wr ? buf_addr :
                       {buf_addr[31:offset_w + 2], {(offset_w + 2){1'b0}}};
    assign mem_wdata = buf_wdata;
    assign mem_wstrb = buf_wstrb;

    dcache_req_buf u_req_buf (
        .clk       (clk),
        .rstn      (rstn),
        .buf_we    (buf_we),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_wstrb (req_wstrb),
        .req_wdata (req_wdata),
        .buf_op    (buf_op),
        .buf_addr  (buf_addr),
        .buf_wstrb (buf_wstrb),
        .buf_wdata (buf_wdata)
    );

    dcache_ways u_ways (
        .clk         (clk),
        .rstn        (rstn),
        .lookup_addr (buf_addr),
        .buf_addr    (buf_addr),
        .buf_wstrb   (buf_wstrb),
        .buf_wdata   (buf_wdata),
        .way_we      (way_we),
        .refill      (refill),
        .inval_set   (inval_set),
        .sel_way     (sel_way),
        .sel_return  (sel_return),
        .mem_rdata   (mem_rdata),
        .hit         (hit),
        .rdata       (rdata)
    );

    dcache_lru u_lru (
        .clk    (clk),
        .rstn   (rstn),
        .index  (buf_addr[2 + offset_w +: index_w]),
        .use0   (use0),
        .use1   (use1),
        .victim (victim)
    );

    dcache_fsm u_fsm (
        .clk         (clk),
        .rstn        (rstn),
        .req_valid   (req_valid),
        .req_op      (req_op),
        .buf_op      (buf_op),
        .hit         (hit),
        .victim      (victim),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .req_ready   (req_ready),
        .rdata_valid (rdata_valid),
        .buf_we      (buf_we),
        .way_we      (way_we),
        .refill      (refill),
        .inval_set   (inval_set),
        .sel_way     (sel_way),
        .sel_return  (sel_return),
        .use0        (use0),
        .use1        (use1),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr)
    );

endmodule

// File: verilog/dcache_fsm.sv
////////////////////////////////////////////////////////////
// cache controller, sequences lookup, refill, write-through
// and invalidate, and drives both handshakes
////////////////////////////////////////////////////////////
module dcache_fsm (
    input  logic               clk,
    input  logic               rstn,
    input  logic               req_valid,
    input  dcache_pkg::req_op_e req_op,
    input  dcache_pkg::req_op_e buf_op,
    input  logic [1:0]         hit,
    input  logic               victim,
    input  logic               mem_addr_ok,
    input  logic               mem_data_ok,
    output logic               req_ready,
    output logic               rdata_valid,
    output logic               buf_we,
    output logic [1:0]         way_we,
    output logic               refill,
    output logic               inval_set,
    output logic               sel_way,
    output logic               sel_return,
    output logic               use0,
    output logic               use1,
    output logic               mem_req,
    output logic               mem_wr
);
    import dcache_pkg::*;

    fsm_state_e state;
    fsm_state_e next_state;
    fsm_state_e take_next;

    // where the FSM goes when it can take a new request
    assign take_next = !req_valid         ? st_idle :
                       (req_op == op_inval) ? st_inval : st_lookup;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////////////

    always_comb begin
        case (state)
            st_idle: next_state = take_next;
            st_lookup: begin
                if (hit == 2'b00) begin
                    next_state = (buf_op == op_store) ? st_miss_wr : st_miss_rd;
                end else if (buf_op == op_store) begin
                    next_state = st_hit_wr;
                end else begin
                    // load hit keeps the pipe flowing
                    next_state = take_next;
                end
            end
            st_miss_rd:      next_state = mem_addr_ok ? st_miss_rd_wait : st_miss_rd;
            st_miss_rd_wait: next_state = mem_data_ok ? take_next : st_miss_rd_wait;
            st_miss_wr:      next_state = mem_addr_ok ? take_next : st_miss_wr;
            st_hit_wr:       next_state = mem_addr_ok ? take_next : st_hit_wr;
            st_inval:        next_state = st_idle;
            default:         next_state = st_idle;
        endcase
    end

    //////////////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////////////

    always_comb begin
        req_ready   = 1'b0;
        rdata_valid = 1'b0;
        way_we      = 2'b00;
        refill      = 1'b0;
        inval_set   = 1'b0;
        sel_way     = hit[1];
        sel_return  = 1'b0;
        use0        = 1'b0;
        use1        = 1'b0;
        mem_req     = 1'b0;
        mem_wr      = 1'b0;
        case (state)
            st_idle: req_ready = 1'b1;
            st_lookup: begin
                if (next_state == st_hit_wr) begin
                    // byte merge into the hit way now, memory write follows
                    way_we = hit;
                    use0   = hit[0];
                    use1   = hit[1];
                end else if (hit != 2'b00) begin
                    req_ready   = 1'b1;
                    rdata_valid = 1'b1;
                    use0        = hit[0];
                    use1        = hit[1];
                end
            end
            st_miss_rd: mem_req = 1'b1;
            st_miss_rd_wait: begin
                if (next_state != st_miss_rd_wait) begin
                    req_ready   = 1'b1;
                    rdata_valid = 1'b1;
                    sel_return  = 1'b1;
                    refill      = 1'b1;
                    way_we      = victim ? 2'b10 : 2'b01;
                    use0        = !victim;
                    use1        = victim;
                end
            end
            st_miss_wr, st_hit_wr: begin
                mem_req   = 1'b1;
                mem_wr    = 1'b1;
                req_ready = (next_state != state);
            end
            st_inval: inval_set = 1'b1;
            default: ;
        endcase
    end

    assign buf_we = req_ready && req_valid;

    // memory request is held with its direction until accepted
    a_mem_req_hold: assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_addr_ok |=> mem_req && $stable(mem_wr));

    // load data only ever answers a buffered load
    a_rdata_not_store: assert property (@(posedge clk) disable iff (!rstn)
        rdata_valid |-> buf_op != op_store);

endmodule

// File: verilog/dcache_lru.sv
////////////////////////////////////////////////////////////
// one replacement bit per set, naming the way to evict
////////////////////////////////////////////////////////////
module dcache_lru (
    input  logic       clk,
    input  logic       rstn,
    input  logic [3:0] index,
    input  logic       use0,
    input  logic       use1,
    output logic       victim
);
    import dcache_pkg::*;

    logic [num_sets-1:0] lru_q;

    assign victim = lru_q[index];

    // the way not touched last is the next victim
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lru_q <= '0;
        end else if (use0) begin
            lru_q[index] <= 1'b1;
        end else if (use1) begin
            lru_q[index] <= 1'b0;
        end
    end

endmodule

// File: verilog/dcache_ways.sv
////////////////////////////////////////////////////////////
// tag, valid and line storage for both ways with hit compare
// reads follow lookup_addr, writes and invalidates buf_addr
////////////////////////////////////////////////////////////
module dcache_ways (
    input  logic         clk,
    input  logic         rstn,
    input  logic [31:0]  lookup_addr,
    input  logic [31:0]  buf_addr,
    input  logic [3:0]   buf_wstrb,
    input  logic [31:0]  buf_wdata,
    input  logic [1:0]   way_we,
    input  logic         refill,
    input  logic         inval_set,
    input  logic         sel_way,
    input  logic         sel_return,
    input  logic [127:0] mem_rdata,
    output logic [1:0]   hit,
    output logic [31:0]  rdata
);
    import dcache_pkg::*;

    logic [num_sets-1:0] valid_q [2];
    logic [tag_w-1:0]    tag_q   [2][num_sets];
    logic [line_w-1:0]   data_q  [2][num_sets];
    logic [line_w-1:0]   merged  [2];
    logic [line_w-1:0]   line_sel;

    logic [offset_w-1:0] rd_off;
    logic [index_w-1:0]  rd_idx;
    logic [tag_w-1:0]    rd_tag;
    logic [offset_w-1:0] wr_off;
    logic [index_w-1:0]  wr_idx;
    logic [tag_w-1:0]    wr_tag;

    assign rd_off = lookup_addr[2 +: offset_w];
    assign rd_idx = lookup_addr[2 + offset_w +: index_w];
    assign rd_tag = lookup_addr[31 -: tag_w];
    assign wr_off = buf_addr[2 + offset_w - 1 -: offset_w];
    assign wr_idx = buf_addr[2 + offset_w +: index_w];
    assign wr_tag = buf_addr[31 -: tag_w];

    //////////////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////////////

    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit[w] = valid_q[w][rd_idx] && (tag_q[w][rd_idx] == rd_tag);
        end
    end

    // a returning refill line bypasses the arrays
    assign line_sel = sel_return ? mem_rdata : data_q[sel_way][rd_idx];
    assign rdata    = line_sel[rd_off * 32 +: 32];

    //////////////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////////////

    // store word merged into the current line, per byte lane
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            merged[w] = data_q[w][wr_idx];
            for (int b = 0; b < 4; b++) begin
                if (buf_wstrb[b]) begin
                    merged[w][wr_off * 32 + b * 8 +: 8] = buf_wdata[b * 8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
        end else if (inval_set) begin
            valid_q[0][wr_idx] <= 1'b0;
            valid_q[1][wr_idx] <= 1'b0;
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (way_we[w] && refill) begin
                    valid_q[w][wr_idx] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (way_we[w]) begin
                if (refill) begin
                    tag_q[w][wr_idx]  <= wr_tag;
                    data_q[w][wr_idx] <= mem_rdata;
                end else begin
                    data_q[w][wr_idx] <= merged[w];
                end
            end
        end
    end

    // refill only goes to a missing line, so a tag never lives in both ways
    a_hit_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(hit));

endmodule

// File: verilog/dcache_req_buf.sv
////////////////////////////////////////////////////////////
// request buffer, loaded on acceptance and held until the next
////////////////////////////////////////////////////////////
module dcache_req_buf (
    input  logic               clk,
    input  logic               rstn,
    input  logic               buf_we,
    input  dcache_pkg::req_op_e req_op,
    input  logic [31:0]        req_addr,
    input  logic [3:0]         req_wstrb,
    input  logic [31:0]        req_wdata,
    output dcache_pkg::req_op_e buf_op,
    output logic [31:0]        buf_addr,
    output logic [3:0]         buf_wstrb,
    output logic [31:0]        buf_wdata
);
    import dcache_pkg::*;

    // opcode and address of the accepted request
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            buf_op   <= op_load;
            buf_addr <= '0;
        end else if (buf_we) begin
            buf_op   <= req_op;
            buf_addr <= req_addr;
        end
    end

    // store payload
    always_ff @(posedge clk) begin
        if (buf_we) begin
            buf_wstrb <= req_wstrb;
            buf_wdata <= req_wdata;
        end
    end

endmodule

// File: verilog/dcache_pkg.sv
////////////////////////////////////////////////////////////
// cache geometry and shared enums for the data cache
// imported by every cache module and by the testbench
////////////////////////////////////////////////////////////
package dcache_pkg;

    //////////////////////////////////////////////////////////
    // geometry
    //////////////////////////////////////////////////////////

    // address split is tag | index | word | byte
    localparam int index_w  = 4;
    localparam int offset_w = 2;
    localparam int tag_w    = 32 - index_w - offset_w - 2;
    localparam int num_sets = 16;
    localparam int line_w   = 128;

    //////////////////////////////////////////////////////////
    // enums
    //////////////////////////////////////////////////////////

    // request opcode from the pipeline
    typedef enum logic [1:0] {
        op_load,
        op_store,
        op_inval
    } req_op_e;

    // main controller states
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_miss_rd,
        st_miss_rd_wait,
        st_miss_wr,
        st_hit_wr,
        st_inval
    } fsm_state_e;

endpackage
